// File: verilog/gb_shell_pkg.sv
/*
 * shared definitions for the core shell glue logic
 * plain vector types, video, audio and bridge structs, ff state enum
 * palette reset value, sync timing and bridge address map
 */
package gb_shell_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // plain types

    typedef logic [23:0]  rgb24_t;
    typedef logic [15:0]  sample_t;
    typedef logic [31:0]  bridge_addr_t;
    typedef logic [31:0]  bridge_data_t;
    // four 24-bit colours on top, 32 reserved bits below
    typedef logic [127:0] palette_t;

    ////////////////////////////////////////////////////////////////////////////
    // structs

    // raw LCD side
    typedef struct packed {
        logic   hs;
        logic   vs;
        logic   hblank;
        logic   vblank;
        rgb24_t rgb;
    } video_in_t;

    // scaler side
    typedef struct packed {
        logic   de;
        logic   hs;
        logic   vs;
        rgb24_t rgb;
    } video_out_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } audio_pair_t;

    // single-beat register bus, no back-pressure
    typedef struct packed {
        bridge_addr_t addr;
        logic         rd;
        logic         wr;
        bridge_data_t wr_data;
    } bridge_req_t;

    typedef enum logic [1:0] {
        FF_OFF,
        FF_PRESSED,
        FF_LATCHED,
        FF_UNLATCHING
    } ff_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // constants

    localparam palette_t palette_default = 128'h8282_1451_7356_305A_5F1A_3B49_0000_0000;

    localparam int hs_delay_cycles = 7;
    localparam int hs_delay_width  = $clog2(hs_delay_cycles + 1);

    // overscan flag at bit 14, square pixels at bit 13
    localparam rgb24_t video_slot_word = 24'h00_6000;

    // 0.2 s at 16 MHz
    localparam int ff_tap_cycles  = 3_200_000;
    localparam int ff_count_width = $clog2(ff_tap_cycles + 1);
    // trig_l1 in the controller key bitmap
    localparam int ff_button_bit  = 8;

    // readback window is four words from the base
    localparam bridge_addr_t pal_base_addr = 32'h1000_0000;
    localparam bridge_addr_t pal_load_addr = 32'h1000_0010;

endpackage

// File: verilog/video_out_sync.sv
/*
 * video conditioning for the scaler
 * data enable from blanking, slot word after each active line,
 * delayed one-cycle hsync and one-cycle vsync on the rising edge
 */
module video_out_sync import gb_shell_pkg::*; (
    input  logic       clk_sys,
    input  logic       reset,
    input  video_in_t  video_in,
    output video_out_t video_out
);

    logic                      de;
    logic                      hs_prev;
    logic                      vs_q;
    logic                      vs_prev;
    logic [hs_delay_width-1:0] hs_count;

    // active area when neither blanking flag is set
    assign de = ~(video_in.hblank | video_in.vblank);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            video_out <= '0;
            hs_prev   <= 1'b0;
            vs_q      <= 1'b0;
            vs_prev   <= 1'b0;
            hs_count  <= '0;
        end else begin
            //////////////////////////////////////////////////////////////////////
            // data enable and pixel data

            video_out.de <= de;
            if (de) begin
                video_out.rgb <= video_in.rgb;
            end else if (video_out.de) begin
                // first blank cycle after the line carries the slot word
                video_out.rgb <= video_slot_word;
            end else begin
                video_out.rgb <= '0;
            end

            //////////////////////////////////////////////////////////////////////
            // hsync, delayed so it never lands on the vsync pulse

            hs_prev <= video_in.hs;
            if (~hs_prev & video_in.hs) begin
                hs_count <= hs_delay_width'(hs_delay_cycles);
            end else if (hs_count != '0) begin
                hs_count <= hs_count - 1'b1;
            end
            video_out.hs <= (hs_count == hs_delay_width'(1));

            //////////////////////////////////////////////////////////////////////
            // vsync, one cycle on the rise of the staged input

            vs_q         <= video_in.vs;
            vs_prev      <= vs_q;
            video_out.vs <= vs_q & ~vs_prev;
        end
    end

    // the scaler would take an overlapping pulse pair as a broken frame
    sync_pulses_apart : assert property (
        @(posedge clk_sys) disable iff (reset)
        !(video_out.hs && video_out.vs)
    ) else $error("video_out.hs and video_out.vs high in the same cycle");

endmodule

// File: verilog/palette_store.sv
/*
 * 128-bit palette register with power-on default
 * byte-swapped 16-bit shift load and four-word bridge readback
 */
module palette_store import gb_shell_pkg::*; (
    input  logic         clk_sys,
    input  logic         reset,
    input  bridge_req_t  bridge,
    output bridge_data_t bridge_rd_data,
    output logic [95:0]  pal_rgb
);

    palette_t     palette;
    logic         load_hit;
    logic         in_window;
    logic [1:0]   word_sel;
    bridge_data_t rd_word;

    assign load_hit = bridge.wr && (bridge.addr == pal_load_addr);

    // word aligned, four words from the base
    assign in_window = (bridge.addr[31:4] == pal_base_addr[31:4])
                    && (bridge.addr[1:0] == 2'b00);
    assign word_sel  = bridge.addr[3:2];

    // word 0 is the top of the register
    assign rd_word = in_window ? palette[{~word_sel, 5'd0} +: 32] : '0;

    // colours only, reserved bits stay inside
    assign pal_rgb = palette[127:32];

    ////////////////////////////////////////////////////////////////////////////
    // load path

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            palette <= palette_default;
        end else if (load_hit) begin
            // host sends the bytes in the opposite order
            palette <= {palette[111:0], bridge.wr_data[7:0], bridge.wr_data[15:8]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // readback, held until the next read

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            bridge_rd_data <= '0;
        end else if (bridge.rd) begin
            bridge_rd_data <= rd_word;
        end
    end

    // bridge master strobes one direction per cycle
    bridge_strobes_exclusive : assert property (
        @(posedge clk_sys) disable iff (reset)
        !(bridge.rd && bridge.wr)
    ) else $error("bridge rd and wr high in the same cycle");

endmodule

// File: verilog/ff_button_latch.sv
/*
 * fast-forward button logic
 * hold for momentary fast-forward, short tap toggles a latch
 */
module ff_button_latch import gb_shell_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic [31:0] cont1_key,
    input  logic        osd_active,
    output logic        fast_forward
);

    ff_state_t                 state;
    ff_state_t                 state_next;
    logic                      pressed;
    logic                      tap_short;
    logic [ff_count_width-1:0] hold_count;

    // menu open means the button belongs to the menu
    assign pressed   = cont1_key[ff_button_bit] & ~osd_active;
    assign tap_short = hold_count < ff_count_width'(ff_tap_cycles);

    always_comb begin
        state_next = state;
        case (state)
            FF_OFF: begin
                if (pressed) state_next = FF_PRESSED;
            end
            FF_PRESSED: begin
                if (!pressed) state_next = tap_short ? FF_LATCHED : FF_OFF;
            end
            FF_LATCHED: begin
                if (pressed) state_next = FF_UNLATCHING;
            end
            FF_UNLATCHING: begin
                if (!pressed) state_next = FF_OFF;
            end
            default: begin
                state_next = FF_OFF;
            end
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state        <= FF_OFF;
            hold_count   <= '0;
            fast_forward <= 1'b0;
        end else begin
            state <= state_next;

            // hold time, saturates once the tap window is over
            if (state != FF_PRESSED) begin
                hold_count <= '0;
            end else if (tap_short) begin
                hold_count <= hold_count + 1'b1;
            end

            // next state so the latch takes over without a gap on release
            fast_forward <= pressed | (state_next == FF_LATCHED);
        end
    end

endmodule

// File: verilog/audio_out_stage.sv
/*
 * stereo output register with mute during fast-forward
 */
module audio_out_stage import gb_shell_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  audio_pair_t audio_in,
    input  logic        fast_forward,
    input  logic        mute_on_ff,
    output audio_pair_t audio_out
);

    logic mute;

    assign mute = fast_forward & mute_on_ff;

    // one register per channel, also eases timing into the audio path
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            audio_out <= '0;
        end else begin
            audio_out.left  <= mute ? sample_t'(0) : audio_in.left;
            audio_out.right <= mute ? sample_t'(0) : audio_in.right;
        end
    end

endmodule

// File: verilog/gb_shell_top.sv
/*
 * top level of the core shell glue
 * video conditioning, palette store, fast-forward latch, audio stage
 */
module gb_shell_top import gb_shell_pkg::*; (
    input  logic         clk_sys,
    input  logic         reset,

    // LCD in, scaler out
    input  video_in_t    video_in,
    output video_out_t   video_out,

    // audio
    input  audio_pair_t  audio_in,
    input  logic         mute_on_ff,
    output audio_pair_t  audio_out,

    // controller and menu
    input  logic [31:0]  cont1_key,
    input  logic         osd_active,
    output logic         fast_forward,

    // bridge register bus
    input  bridge_req_t  bridge,
    output bridge_data_t bridge_rd_data,

    // to the colour mapping stage
    output logic [95:0]  palette_colours
);

    ////////////////////////////////////////////////////////////////////////////
    // video

    video_out_sync i_video_out_sync (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .video_in  (video_in),
        .video_out (video_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // palette

    palette_store i_palette_store (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .pal_rgb        (palette_colours)
    );

    ////////////////////////////////////////////////////////////////////////////
    // fast-forward and audio

    ff_button_latch i_ff_button_latch (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cont1_key    (cont1_key),
        .osd_active   (osd_active),
        .fast_forward (fast_forward)
    );

    // mute follows the same fast-forward that leaves the shell
    audio_out_stage i_audio_out_stage (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .audio_in     (audio_in),
        .fast_forward (fast_forward),
        .mute_on_ff   (mute_on_ff),
        .audio_out    (audio_out)
    );

endmodule

// File: testbench/tb_gb_shell.sv
/*
 * testbench for the core shell glue
 * clock, reset, video, bridge, button and audio stimulus
 * reference models and concurrent checks on every DUT output
 */
module tb_gb_shell import gb_shell_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    // longest branch runs about 850 cycles
    localparam int timeout_cycles = 4000;

    logic         clk_sys = 1'b0;
    logic         reset;
    video_in_t    video_in;
    video_out_t   video_out;
    audio_pair_t  audio_in;
    logic         mute_on_ff;
    audio_pair_t  audio_out;
    logic [31:0]  cont1_key;
    logic         osd_active;
    logic         fast_forward;
    bridge_req_t  bridge;
    bridge_data_t bridge_rd_data;
    logic [95:0]  palette_colours;

    // reference model state
    logic         de_in;
    logic [1:0]   de_hist;
    rgb24_t       rgb_d;
    logic [8:0]   hs_hist;
    logic [2:0]   vs_hist;
    audio_pair_t  audio_d;
    logic         mute_d;
    logic         pressed_in;
    logic         pressed_d;
    logic         tap_latched;
    palette_t     pal_model;
    bridge_data_t rd_hold;
    rgb24_t       rgb_expected;
    audio_pair_t  audio_expected;
    logic         ff_expected;
    logic [91:0]  post_reset_outputs;
    int           slot_events;
    int           hs_events;
    int           vs_events;
    int           latch_toggles;
    int           cycle_count = 0;

    always #4 clk_sys = ~clk_sys;

    gb_shell_top i_dut (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .video_in        (video_in),
        .video_out       (video_out),
        .audio_in        (audio_in),
        .mute_on_ff      (mute_on_ff),
        .audio_out       (audio_out),
        .cont1_key       (cont1_key),
        .osd_active      (osd_active),
        .fast_forward    (fast_forward),
        .bridge          (bridge),
        .bridge_rd_data  (bridge_rd_data),
        .palette_colours (palette_colours)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference models

    // word i of the readback window counts from the top of the palette
    function automatic bridge_data_t expected_read(bridge_addr_t addr, palette_t pal);
        bridge_data_t word;
        word = '0;
        for (int i = 0; i < 4; i++) begin
            if (addr == pal_base_addr + bridge_addr_t'(4 * i)) begin
                word = pal[127 - 32 * i -: 32];
            end
        end
        return word;
    endfunction

    assign de_in              = !(video_in.hblank || video_in.vblank);
    assign pressed_in         = cont1_key[ff_button_bit] && !osd_active;
    assign rgb_expected       = de_hist[0] ? rgb_d : (de_hist[1] ? video_slot_word : '0);
    assign audio_expected     = mute_d ? '0 : audio_d;
    assign ff_expected        = pressed_d || tap_latched;
    assign post_reset_outputs = {video_out, audio_out, fast_forward, bridge_rd_data};

    always @(posedge clk_sys) begin
        if (reset) begin
            de_hist       <= '0;
            rgb_d         <= '0;
            hs_hist       <= '0;
            vs_hist       <= '0;
            audio_d       <= '0;
            mute_d        <= 1'b0;
            pressed_d     <= 1'b0;
            tap_latched   <= 1'b0;
            pal_model     <= palette_default;
            rd_hold       <= '0;
            slot_events   <= 0;
            hs_events     <= 0;
            vs_events     <= 0;
            latch_toggles <= 0;
        end else begin
            de_hist   <= {de_hist[0], de_in};
            rgb_d     <= video_in.rgb;
            hs_hist   <= {hs_hist[7:0], video_in.hs};
            vs_hist   <= {vs_hist[1:0], video_in.vs};
            audio_d   <= audio_in;
            mute_d    <= ff_expected && mute_on_ff;
            pressed_d <= pressed_in;
            // every press here is far shorter than the tap window
            if (pressed_d && !pressed_in) begin
                tap_latched   <= !tap_latched;
                latch_toggles <= latch_toggles + 1;
            end
            if (bridge.wr && bridge.addr == pal_load_addr) begin
                pal_model <= {pal_model[111:0], bridge.wr_data[7:0], bridge.wr_data[15:8]};
            end
            if (bridge.rd) begin
                rd_hold <= expected_read(bridge.addr, pal_model);
            end
            if (de_hist[1] && !de_hist[0]) slot_events <= slot_events + 1;
            if (hs_hist[7] && !hs_hist[8]) hs_events <= hs_events + 1;
            if (vs_hist[1] && !vs_hist[2]) vs_events <= vs_events + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic report_mismatch(string name, logic [127:0] expected, logic [127:0] actual);
        $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    reset_values : assert property (@(posedge clk_sys) $fell(reset) |-> post_reset_outputs == '0)
        else report_mismatch("outputs after reset", '0, $sampled(post_reset_outputs));

    de_follows : assert property (@(posedge clk_sys) disable iff (reset)
        video_out.de == de_hist[0])
        else report_mismatch("video_out.de", $sampled(de_hist[0]), $sampled(video_out.de));

    rgb_follows : assert property (@(posedge clk_sys) disable iff (reset)
        video_out.rgb == rgb_expected)
        else report_mismatch("video_out.rgb", $sampled(rgb_expected), $sampled(video_out.rgb));

    slot_after_line : assert property (@(posedge clk_sys) disable iff (reset)
        (de_hist[1] && !de_hist[0]) |-> video_out.rgb == video_slot_word)
        else report_mismatch("video_out.rgb slot", video_slot_word, $sampled(video_out.rgb));

    // pulse eight sampling edges after the input rise
    hs_pulse : assert property (@(posedge clk_sys) disable iff (reset)
        video_out.hs == (hs_hist[7] && !hs_hist[8]))
        else report_mismatch("video_out.hs", $sampled(hs_hist[7] && !hs_hist[8]),
                             $sampled(video_out.hs));

    vs_pulse : assert property (@(posedge clk_sys) disable iff (reset)
        video_out.vs == (vs_hist[1] && !vs_hist[2]))
        else report_mismatch("video_out.vs", $sampled(vs_hist[1] && !vs_hist[2]),
                             $sampled(video_out.vs));

    palette_readback : assert property (@(posedge clk_sys) disable iff (reset)
        bridge_rd_data == rd_hold)
        else report_mismatch("bridge_rd_data", $sampled(rd_hold), $sampled(bridge_rd_data));

    palette_export : assert property (@(posedge clk_sys) disable iff (reset)
        palette_colours == pal_model[127:32])
        else report_mismatch("palette_colours", $sampled(pal_model[127:32]),
                             $sampled(palette_colours));

    ff_output : assert property (@(posedge clk_sys) disable iff (reset)
        fast_forward == ff_expected)
        else report_mismatch("fast_forward", $sampled(ff_expected), $sampled(fast_forward));

    audio_output : assert property (@(posedge clk_sys) disable iff (reset)
        audio_out == audio_expected)
        else report_mismatch("audio_out", $sampled(audio_expected), $sampled(audio_out));

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout: stimulus still running after %0d cycles", timeout_cycles);
            $display("TB FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic bridge_read(bridge_addr_t addr);
        @(posedge clk_sys);
        bridge.addr <= addr;
        bridge.rd   <= 1'b1;
        @(posedge clk_sys);
        bridge.rd   <= 1'b0;
    endtask

    task automatic bridge_write(bridge_addr_t addr, bridge_data_t data);
        @(posedge clk_sys);
        bridge.addr    <= addr;
        bridge.wr_data <= data;
        bridge.wr      <= 1'b1;
        @(posedge clk_sys);
        bridge.wr      <= 1'b0;
    endtask

    // four palette words, then addresses outside the window
    task automatic read_window();
        for (int i = 0; i < 4; i++) begin
            bridge_read(pal_base_addr + bridge_addr_t'(4 * i));
        end
        bridge_read(pal_base_addr + 32'h20);
        bridge_read(pal_load_addr);
    endtask

    task automatic load_palette_random(int count);
        bridge_data_t data;
        for (int i = 0; i < count; i++) begin
            data = $urandom;
            bridge_write(pal_load_addr, data);
        end
    endtask

    task automatic run_video(int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk_sys);
            video_in.hblank <= ($urandom % 4) == 0;
            video_in.vblank <= ($urandom % 16) == 0;
            video_in.rgb    <= rgb24_t'($urandom);
            // hsync every 20 cycles, vsync rises mid line so the pulses stay apart
            video_in.hs     <= (n % 20) < 3;
            video_in.vs     <= (n % 100) >= 10 && (n % 100) < 40;
        end
    endtask

    task automatic drive_audio(int cycles);
        repeat (cycles) begin
            @(posedge clk_sys);
            audio_in <= audio_pair_t'($urandom);
        end
    endtask

    // other key bits toggle at random around the trigger
    task automatic press_button(int hold_cycles);
        @(posedge clk_sys);
        cont1_key <= $urandom | (32'h1 << ff_button_bit);
        repeat (hold_cycles) @(posedge clk_sys);
        cont1_key <= $urandom & ~(32'h1 << ff_button_bit);
    endtask

    task automatic fast_forward_sequence();
        @(posedge clk_sys);
        mute_on_ff <= 1'b1;
        // hold, then taps that clear and latch again
        press_button(40);
        repeat (20) @(posedge clk_sys);
        press_button(4);
        repeat (20) @(posedge clk_sys);
        press_button(4);
        repeat (20) @(posedge clk_sys);
        // latched with mute off
        mute_on_ff <= 1'b0;
        repeat (30) @(posedge clk_sys);
        mute_on_ff <= 1'b1;
        // menu open, button ignored while latched
        osd_active <= 1'b1;
        press_button(6);
        repeat (10) @(posedge clk_sys);
        osd_active <= 1'b0;
        press_button(4);
        repeat (20) @(posedge clk_sys);
        // menu open, button ignored while off
        osd_active <= 1'b1;
        press_button(6);
        repeat (10) @(posedge clk_sys);
        osd_active <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'hd617));
        reset           = 1'b1;
        video_in        = '0;
        video_in.hblank = 1'b1;
        video_in.vblank = 1'b1;
        audio_in        = '0;
        mute_on_ff      = 1'b0;
        cont1_key       = '0;
        osd_active      = 1'b0;
        bridge          = '0;
        repeat (4) @(posedge clk_sys);
        reset <= 1'b0;

        fork
            run_video(800);
            begin
                fork
                    drive_audio(280);
                    fast_forward_sequence();
                join
            end
            begin
                read_window();
                load_palette_random(8);
                read_window();
            end
        join
        repeat (10) @(posedge clk_sys);

        if (slot_events == 0 || hs_events == 0 || vs_events == 0 || latch_toggles < 4) begin
            $display("stimulus never reached the slot word, sync pulses or button taps");
            $display("TB FAILED");
            $fatal(1, "coverage of the checks incomplete");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: list.f
verilog/gb_shell_pkg.sv
verilog/video_out_sync.sv
verilog/palette_store.sv
verilog/ff_button_latch.sv
verilog/audio_out_stage.sv
verilog/gb_shell_top.sv
testbench/tb_gb_shell.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the fail message

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_gb_shell -f list.f -o tb_gb_shell \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_gb_shell > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
